// File: flist.f
hdl/immu_pkg.sv
hdl/tlb_entry_ram.sv
hdl/immu_spr_port.sv
hdl/immu_xlate.sv
hdl/immu_top.sv
tb/tb_immu_top.sv

// File: run.sh
#!/bin/sh
# Builds the instruction MMU testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_immu_top -Mdir obj_dir -f flist.f

./obj_dir/Vtb_immu_top > sim.log 2>&1
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

// File: tb/tb_immu_top.sv
// Testbench that checks SPR fills and fetch lookups of the instruction MMU against a model
module tb_immu_top
   import immu_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int set_w = 6;
   localparam int sets = 1 << set_w;
   localparam int ack_limit = 16;

   logic              clk;
   logic              rst;
   logic              enable_i;
   logic [addr_w-1:0] virt_addr_i;
   logic [addr_w-1:0] virt_addr_match_i;
   logic              supervisor_mode_i;
   spr_req_t          spr_req_i;
   logic [addr_w-1:0] phys_addr_o;
   logic              cache_inhibit_o;
   logic              tlb_miss_o;
   logic              pagefault_o;
   logic              busy_o;
   logic [addr_w-1:0] spr_dat_o;
   logic              spr_ack_o;

   // Reference copies of both tables
   logic [addr_w-1:0] match_model [sets];
   logic [addr_w-1:0] trans_model [sets];

   int                checks;
   int                errors;
   bit                timed_out;

   // What the last SPR access showed
   logic              busy_at_stb;
   logic              miss_at_stb;
   logic              fault_at_stb;
   logic              busy_at_ack;
   logic              miss_at_ack;
   logic              fault_at_ack;
   logic [addr_w-1:0] read_word;

   immu_top #(.SET_WIDTH(set_w)) DUT (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch %s: got %08h expected %08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   // One SPR access that holds the strobe for two ack cycles to show the held read data
   task automatic spr_access(input logic [15:0] addr, input logic we, input logic [31:0] dat);
      int          cycles;
      logic        got_ack;
      logic [31:0] first_word;
      cycles  = 0;
      got_ack = 1'b0;
      if (timed_out) return;
      @(negedge clk);
      spr_req_i.addr = addr;
      spr_req_i.we   = we;
      spr_req_i.dat  = dat;
      spr_req_i.stb  = 1'b1;
      #2;
      busy_at_stb  = busy_o;
      miss_at_stb  = tlb_miss_o;
      fault_at_stb = pagefault_o;
      while (!got_ack && cycles < ack_limit) begin
         @(negedge clk);
         cycles++;
         got_ack = spr_ack_o;
      end
      expect_true(got_ack, $sformatf("no SPR ack for address %04h before the timeout", addr));
      if (!got_ack) begin
         timed_out = 1'b1;
         spr_req_i.stb = 1'b0;
         return;
      end
      expect_true(cycles == 1, "SPR ack did not come one cycle after the strobe");
      busy_at_ack  = busy_o;
      miss_at_ack  = tlb_miss_o;
      fault_at_ack = pagefault_o;
      first_word   = spr_dat_o;
      @(negedge clk);
      expect_true(spr_ack_o, "SPR ack dropped while the strobe was still high");
      if (!we) begin
         compare_value("spr_dat_o (held)", spr_dat_o, first_word);
      end
      read_word     = first_word;
      spr_req_i.stb = 1'b0;
      spr_req_i.we  = 1'b0;
   endtask

   task automatic write_entry(input logic is_trans, input logic [set_w-1:0] idx,
                              input logic [31:0] word);
      spr_access((is_trans ? spr_trans_base : spr_match_base) | 16'(idx), 1'b1, word);
      if (is_trans) begin
         trans_model[idx] = word;
      end else begin
         match_model[idx] = word;
      end
   endtask

   task automatic read_check(input logic is_trans, input logic [set_w-1:0] idx);
      spr_access((is_trans ? spr_trans_base : spr_match_base) | 16'(idx), 1'b0, '0);
      compare_value("spr_dat_o", read_word, is_trans ? trans_model[idx] : match_model[idx]);
   endtask

   // Valid or invalid normal entry for va with the huge set made non-huge
   task automatic install_normal(input logic [31:0] va, input logic valid,
                                 input logic [vpn_w-1:0] vpn_xor);
      itlb_match_t      m;
      logic [set_w-1:0] nidx;
      logic [set_w-1:0] hidx;
      nidx = va[page_bits +: set_w];
      hidx = va[huge_bits +: set_w];
      if (hidx != nidx) begin
         m     = match_model[hidx];
         m.pl1 = 1'b0;
         write_entry(1'b0, hidx, m);
      end
      m       = $urandom();
      m.vpn   = va[31:13] ^ vpn_xor;
      m.pl1   = 1'b0;
      m.valid = valid;
      write_entry(1'b0, nidx, m);
      write_entry(1'b1, nidx, $urandom());
   endtask

   // Huge entry for va whose vpn bits 18:11 stand for address bits 31:24
   task automatic install_huge(input logic [31:0] va, input logic [7:0] tag_xor);
      itlb_match_t      m;
      logic [set_w-1:0] hidx;
      hidx            = va[huge_bits +: set_w];
      m               = $urandom();
      m.vpn[18:11]    = va[31:24] ^ tag_xor;
      m.pl1           = 1'b1;
      m.valid         = 1'b1;
      write_entry(1'b0, hidx, m);
      write_entry(1'b1, hidx, $urandom());
   endtask

   // Present va for two cycles and compare against the model
   task automatic translate_check(input logic [31:0] va, input logic sup);
      itlb_match_t m;
      itlb_trans_t t;
      logic        exp_miss;
      logic [31:0] exp_pa;
      if (timed_out) return;
      @(negedge clk);
      virt_addr_i       = va;
      virt_addr_match_i = va;
      supervisor_mode_i = sup;
      repeat (2) @(negedge clk);
      m = match_model[va[huge_bits +: set_w]];
      if (m.pl1 && m.valid) begin
         t        = trans_model[va[huge_bits +: set_w]];
         exp_miss = m.vpn[18:11] != va[31:24];
         exp_pa   = {t.ppn[18:11], va[23:0]};
      end else begin
         m        = match_model[va[page_bits +: set_w]];
         t        = trans_model[va[page_bits +: set_w]];
         exp_miss = !m.valid || (m.vpn != va[31:13]);
         exp_pa   = {t.ppn, va[12:0]};
      end
      compare_value("tlb_miss_o", 32'(tlb_miss_o), 32'(exp_miss));
      if (!exp_miss) begin
         compare_value("phys_addr_o", phys_addr_o, exp_pa);
         compare_value("cache_inhibit_o", 32'(cache_inhibit_o), 32'(t.ci));
         compare_value("pagefault_o", 32'(pagefault_o), 32'(sup ? !t.sxe : !t.uxe));
      end
   endtask

   task automatic report_test(input string name, input int start);
      if (errors == start) begin
         $display("Test %s: ok", name);
      end else begin
         $display("Test %s: %0d errors", name, errors - start);
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] va;
      logic [15:0] side;
      int          start;
      r = $urandom(32'h1729b627);
      checks = 0;
      errors = 0;
      timed_out = 1'b0;
      rst = 1'b1;
      enable_i = 1'b0;
      virt_addr_i = '0;
      virt_addr_match_i = '0;
      supervisor_mode_i = 1'b0;
      spr_req_i = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      enable_i = 1'b1;

      start = errors;
      for (int i = 0; i < sets; i++) begin
         write_entry(1'b0, i[set_w-1:0], $urandom());
         write_entry(1'b1, i[set_w-1:0], $urandom());
      end
      for (int i = 0; i < 24; i++) begin
         r = $urandom();
         write_entry(r[8], r[set_w-1:0], $urandom());
      end
      for (int i = 0; i < 48; i++) begin
         r = $urandom();
         read_check(r[8], r[set_w-1:0]);
      end
      report_test("SPR write and readback", start);

      start = errors;
      for (int i = 0; i < 24; i++) begin
         va = $urandom();
         install_normal(va, 1'b1, '0);
         translate_check(va, va[0]);
      end
      report_test("normal page hit", start);

      start = errors;
      for (int i = 0; i < 24; i++) begin
         va = $urandom();
         r = $urandom();
         install_normal(va, r[0], r[0] ? vpn_w'(1) << (int'(r[12:8]) % vpn_w) : '0);
         translate_check(va, r[1]);
      end
      report_test("miss", start);

      start = errors;
      for (int i = 0; i < 24; i++) begin
         va = $urandom();
         r = $urandom();
         install_huge(va, r[0] ? 8'h00 : (r[15:8] | 8'h01));
         translate_check(va, r[1]);
      end
      report_test("huge page", start);

      start = errors;
      for (int i = 0; i < 32; i++) begin
         va = $urandom();
         r = $urandom();
         if (r[0]) begin
            install_normal(va, 1'b1, '0);
         end else begin
            install_huge(va, 8'h00);
         end
         translate_check(va, r[1]);
      end
      report_test("permission", start);

      start = errors;
      for (int i = 0; i < 12; i++) begin
         va = $urandom();
         r = $urandom();
         // A missing address stays on the fetch side so the miss masking shows
         install_normal(va, 1'b0, '0);
         expect_true(busy_at_stb, "busy_o low in the strobe cycle of a table write");
         translate_check(va, 1'b0);
         read_check(r[8], r[set_w-1:0]);
         expect_true(busy_at_stb && busy_at_ack, "busy_o low during a table read");
         expect_true(!miss_at_stb && !miss_at_ack, "tlb_miss_o high while busy_o is high");
         expect_true(!fault_at_stb && !fault_at_ack, "pagefault_o high while busy_o is high");
      end
      for (int i = 0; i < 8; i++) begin
         r = $urandom();
         side = {spr_group_immu, r[10:0]};
         if (side >= spr_match_base && side < spr_trans_end) begin
            side = side ^ 16'h0400;
         end
         spr_access(side, 1'b0, '0);
         compare_value("spr_dat_o", read_word, '0);
         expect_true(!busy_at_stb && !busy_at_ack, "busy_o high for an access outside the tables");
      end
      report_test("busy and side addresses", start);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: hdl/immu_top.sv
// Top level of the instruction MMU, wiring the SPR port, both entry tables and the combiner
module immu_top
   import immu_pkg::*;
#(
   parameter int SET_WIDTH = 6
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              enable_i,
   input  logic [addr_w-1:0] virt_addr_i,
   input  logic [addr_w-1:0] virt_addr_match_i,
   input  logic              supervisor_mode_i,
   input  spr_req_t          spr_req_i,
   output logic [addr_w-1:0] phys_addr_o,
   output logic              cache_inhibit_o,
   output logic              tlb_miss_o,
   output logic              pagefault_o,
   output logic              busy_o,
   output logic [addr_w-1:0] spr_dat_o,
   output logic              spr_ack_o
);

   logic [SET_WIDTH-1:0] match_addr;
   logic                 match_we;
   logic [SET_WIDTH-1:0] trans_addr;
   logic                 trans_we;
   logic [addr_w-1:0]    wr_dat;
   logic [SET_WIDTH-1:0] huge_idx;
   itlb_match_t          match_a;
   itlb_match_t          match_b;
   itlb_trans_t          trans_a;
   itlb_trans_t          trans_b;

   // Port b always looks up the huge-page set
   assign huge_idx = virt_addr_i[huge_bits +: SET_WIDTH];

   immu_spr_port #(
      .SET_WIDTH (SET_WIDTH)
   ) u_spr_port (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .spr_req_i    (spr_req_i),
      .virt_addr_i  (virt_addr_i),
      .match_rd_i   (match_a),
      .trans_rd_i   (trans_a),
      .match_addr_o (match_addr),
      .match_we_o   (match_we),
      .trans_addr_o (trans_addr),
      .trans_we_o   (trans_we),
      .wr_dat_o     (wr_dat),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o),
      .busy_o       (busy_o)
   );

   tlb_entry_ram #(
      .SET_WIDTH (SET_WIDTH)
   ) match_ram (
      .clk      (clk),
      .addr_a_i (match_addr),
      .we_a_i   (match_we),
      .din_a_i  (wr_dat),
      .dout_a_o (match_a),
      .addr_b_i (huge_idx),
      .dout_b_o (match_b)
   );

   tlb_entry_ram #(
      .SET_WIDTH (SET_WIDTH)
   ) trans_ram (
      .clk      (clk),
      .addr_a_i (trans_addr),
      .we_a_i   (trans_we),
      .din_a_i  (wr_dat),
      .dout_a_o (trans_a),
      .addr_b_i (huge_idx),
      .dout_b_o (trans_b)
   );

   immu_xlate #(
      .SET_WIDTH (SET_WIDTH)
   ) u_xlate (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_match_i (virt_addr_match_i),
      .supervisor_mode_i (supervisor_mode_i),
      .busy_i            (busy_o),
      .match_a_i         (match_a),
      .trans_a_i         (trans_a),
      .match_b_i         (match_b),
      .trans_b_i         (trans_b),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o)
   );

endmodule

// File: hdl/immu_xlate.sv
// Translation combiner: merges normal and huge page lookups into address, miss and fault
module immu_xlate
   import immu_pkg::*;
#(
   parameter int SET_WIDTH = 6
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [addr_w-1:0] virt_addr_match_i,
   input  logic              supervisor_mode_i,
   input  logic              busy_i,
   input  itlb_match_t       match_a_i,
   input  itlb_trans_t       trans_a_i,
   input  itlb_match_t       match_b_i,
   input  itlb_trans_t       trans_b_i,
   output logic [addr_w-1:0] phys_addr_o,
   output logic              cache_inhibit_o,
   output logic              tlb_miss_o,
   output logic              pagefault_o
);

   logic                   huge_now;
   logic                   huge_r;
   logic                   huge_sel;
   logic [vpn_w-1:0]       vpn_cmp;
   logic                   tag_miss;
   logic                   set_miss;
   logic                   norm_miss;
   logic                   huge_miss;
   logic                   sxe;
   logic                   uxe;

   // Huge entry wins when it is valid and marked huge
   assign huge_now = match_b_i.pl1 && match_b_i.valid;

   // Keep the last select while the table port is taken by SPR
   assign huge_sel = busy_i ? huge_r : huge_now;

   always_ff @(posedge clk) begin
      if (rst) begin
         huge_r <= 1'b0;
      end else begin
         huge_r <= huge_sel;
      end
   end

   // Normal path compares the tag above the set index and the set bits as written
   assign vpn_cmp   = virt_addr_match_i[addr_w-1:page_bits];
   assign tag_miss  = match_a_i.vpn[vpn_w-1:SET_WIDTH] != vpn_cmp[vpn_w-1:SET_WIDTH];
   assign set_miss  = match_a_i.vpn[SET_WIDTH-1:0] != vpn_cmp[SET_WIDTH-1:0];
   assign norm_miss = tag_miss || set_miss || !match_a_i.valid;

   // Huge path only looks at bits 31:24
   assign huge_miss = (match_b_i.vpn[vpn_w-1 -: huge_tag_w] !=
                       virt_addr_match_i[addr_w-1:huge_bits]) || !match_b_i.valid;

   always_comb begin
      if (huge_sel) begin
         phys_addr_o     = {trans_b_i.ppn[vpn_w-1 -: huge_tag_w],
                            virt_addr_match_i[huge_bits-1:0]};
         cache_inhibit_o = trans_b_i.ci;
         sxe             = trans_b_i.sxe;
         uxe             = trans_b_i.uxe;
      end else begin
         phys_addr_o     = {trans_a_i.ppn, virt_addr_match_i[page_bits-1:0]};
         cache_inhibit_o = trans_a_i.ci;
         sxe             = trans_a_i.sxe;
         uxe             = trans_a_i.uxe;
      end
   end

   // Miss and fault are meaningless while SPR owns the tables
   assign tlb_miss_o  = (huge_sel ? huge_miss : norm_miss) && !busy_i;
   assign pagefault_o = (supervisor_mode_i ? !sxe : !uxe) && !busy_i;

endmodule

// File: hdl/immu_spr_port.sv
// SPR access logic of the instruction MMU: decode, acknowledge, table port steering and busy
module immu_spr_port
   import immu_pkg::*;
#(
   parameter int SET_WIDTH = 6
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable_i,
   input  spr_req_t             spr_req_i,
   input  logic [addr_w-1:0]    virt_addr_i,
   input  logic [addr_w-1:0]    match_rd_i,
   input  logic [addr_w-1:0]    trans_rd_i,
   output logic [SET_WIDTH-1:0] match_addr_o,
   output logic                 match_we_o,
   output logic [SET_WIDTH-1:0] trans_addr_o,
   output logic                 trans_we_o,
   output logic [addr_w-1:0]    wr_dat_o,
   output logic [addr_w-1:0]    spr_dat_o,
   output logic                 spr_ack_o,
   output logic                 busy_o
);

   logic                 grp_sel;
   logic                 match_cs;
   logic                 trans_cs;
   logic                 ack;
   logic                 ack_r;
   logic                 first_ack;
   logic                 match_cs_r;
   logic                 trans_cs_r;
   logic [SET_WIDTH-1:0] spr_idx;
   logic [SET_WIDTH-1:0] fetch_idx;
   logic [addr_w-1:0]    spr_dat;
   logic [addr_w-1:0]    spr_dat_r;

   // Address decode
   assign grp_sel = spr_req_i.stb && (spr_req_i.addr[15:11] == spr_group_immu);

   assign match_cs = spr_req_i.stb &&
                     (spr_req_i.addr >= spr_match_base) &&
                     (spr_req_i.addr < spr_trans_base);
   assign trans_cs = spr_req_i.stb &&
                     (spr_req_i.addr >= spr_trans_base) &&
                     (spr_req_i.addr < spr_trans_end);

   // Ack follows an accepted strobe by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         ack        <= 1'b0;
         ack_r      <= 1'b0;
         match_cs_r <= 1'b0;
         trans_cs_r <= 1'b0;
      end else begin
         ack        <= grp_sel;
         ack_r      <= ack;
         match_cs_r <= match_cs;
         trans_cs_r <= trans_cs;
      end
   end

   assign first_ack = ack && !ack_r;
   assign spr_ack_o = ack && grp_sel;

   // Port a index, SPR set only until the access is acknowledged
   assign spr_idx   = spr_req_i.addr[SET_WIDTH-1:0];
   assign fetch_idx = virt_addr_i[page_bits +: SET_WIDTH];

   assign match_addr_o = (match_cs && !ack) ? spr_idx : fetch_idx;
   assign trans_addr_o = (trans_cs && !ack) ? spr_idx : fetch_idx;

   // Writes land on the edge that raises the ack
   assign match_we_o = match_cs && spr_req_i.we && !ack;
   assign trans_we_o = trans_cs && spr_req_i.we && !ack;
   assign wr_dat_o   = spr_req_i.dat;

   // Unmapped group-2 addresses read as zero
   assign spr_dat = match_cs_r ? match_rd_i :
                    trans_cs_r ? trans_rd_i : '0;

   // Table output moves on after the first ack cycle, so hold a copy
   always_ff @(posedge clk) begin
      if (first_ack) begin
         spr_dat_r <= spr_dat;
      end
   end

   assign spr_dat_o = first_ack ? spr_dat : spr_dat_r;

   // Port a serves SPR before the ack and still shows SPR data on the first ack cycle
   assign busy_o = enable_i &&
                   (((match_cs || trans_cs) && !ack) ||
                    ((match_cs_r || trans_cs_r) && first_ack));

endmodule

// File: hdl/tlb_entry_ram.sv
// Entry table with a read/write port and a read-only port, used for the match and translate sets
module tlb_entry_ram
   import immu_pkg::*;
#(
   parameter int SET_WIDTH = 6
) (
   input  logic                 clk,
   input  logic [SET_WIDTH-1:0] addr_a_i,
   input  logic                 we_a_i,
   input  logic [addr_w-1:0]    din_a_i,
   output logic [addr_w-1:0]    dout_a_o,
   input  logic [SET_WIDTH-1:0] addr_b_i,
   output logic [addr_w-1:0]    dout_b_o
);

   localparam int DEPTH = 1 << SET_WIDTH;

   logic [addr_w-1:0] mem [DEPTH];

   // Port a reads before the write lands, so a written word shows its old value once
   always_ff @(posedge clk) begin
      if (we_a_i) begin
         mem[addr_a_i] <= din_a_i;
      end
      dout_a_o <= mem[addr_a_i];
   end

   // Port b only ever serves the huge-page lookup
   always_ff @(posedge clk) begin
      dout_b_o <= mem[addr_b_i];
   end

endmodule

// File: hdl/immu_pkg.sv
// Shared types and constants of the instruction MMU, imported by every RTL and testbench file
package immu_pkg;

   // Operand and address width of the core
   localparam int addr_w = 32;

   // Page geometry, normal 8 KB pages and huge 16 MB pages
   localparam int page_bits = 13;
   localparam int huge_bits = 24;

   // Widths derived from the page geometry
   localparam int vpn_w = addr_w - page_bits;
   localparam int huge_tag_w = addr_w - huge_bits;

   // SPR map of the unit, group number sits in address bits 15:11
   localparam logic [4:0]  spr_group_immu = 5'd2;
   localparam logic [15:0] spr_match_base = 16'h1200;
   localparam logic [15:0] spr_trans_base = 16'h1280;
   localparam logic [15:0] spr_trans_end  = 16'h1300;

   // Match entry, one per set
   typedef struct packed {
      logic [vpn_w-1:0] vpn;
      logic [10:0]      reserved;
      // Huge page marker
      logic             pl1;
      logic             valid;
   } itlb_match_t;

   // Translate entry, one per set
   typedef struct packed {
      logic [vpn_w-1:0] ppn;
      logic [4:0]       reserved;
      // User and supervisor execute enables
      logic             uxe;
      logic             sxe;
      logic             dirty;
      logic             accessed;
      logic             wom;
      logic             wbc;
      // Cache inhibit and cache coherent
      logic             ci;
      logic             cc;
   } itlb_trans_t;

   // SPR bus request, held stable by the requester until acknowledged
   typedef struct packed {
      logic [15:0]       addr;
      logic              we;
      logic              stb;
      logic [addr_w-1:0] dat;
   } spr_req_t;

endpackage
